// ==== verilog/mask_loader_config.svh ====
// width, count and address step definitions for the mask loader; include wherever a size is needed
`ifndef MASK_LOADER_CONFIG_SVH
`define MASK_LOADER_CONFIG_SVH

// ****************************************
// bus and memory format
// ****************************************

// byte address width on the wishbone port
`define ADDR_BITS 10
// one memory word holds three coefficients plus two spare bits
`define WORD_BITS 32
`define COEFF_BITS 10
`define COEFFS_PER_WORD 3
// bytes between consecutive words
`define WORD_BYTES 4

// ****************************************
// mask geometry
// ****************************************

// bank depth, enough for a 5x5 mask plus spare entries
`define MASK_COEFFS 27
`define COUNT_BITS 4
`define SIZE_BITS 3
// words fetched per supported mask size
`define READS_3X3 3
`define READS_5X5 9

`endif

// ==== verilog/mask_loader_pkg.sv ====
// shared types of the mask loader: vector typedefs, fsm states and the bus structs
`include "mask_loader_config.svh"

package mask_loader_pkg;

	// ****************************************
	// plain vectors
	// ****************************************

	// byte address on the bus
	typedef logic [`ADDR_BITS-1:0] mem_addr_t;
	// raw word as returned by the memory
	typedef logic [`WORD_BITS-1:0] mem_word_t;
	typedef logic [`COEFF_BITS-1:0] coeff_t;
	// whole bank, entry 0 sits in the low bits
	typedef coeff_t [`MASK_COEFFS-1:0] coeff_bank_t;
	// completed reads in the current load
	typedef logic [`COUNT_BITS-1:0] fetch_count_t;
	// mask side length, 3 or 5 supported
	typedef logic [`SIZE_BITS-1:0] mask_size_t;

	// load sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_advance,
		st_loaded
	} load_state_t;

	// ****************************************
	// grouped signals
	// ****************************************

	// load request, sampled with start
	typedef struct packed {
		mask_size_t size;
		mem_addr_t base;
	} mask_cfg_t;

	// master side of a read-only classic cycle
	typedef struct packed {
		logic cyc;
		logic stb;
		mem_addr_t adr;
	} wb_req_t;

	// slave side, dat is valid together with ack
	typedef struct packed {
		logic ack;
		mem_word_t dat;
	} wb_rsp_t;

endpackage

// ==== verilog/mask_load_fsm.sv ====
// sequencer of the mask load: drives the wishbone read cycles and the mask-valid flag
`timescale 1ns/1ps

module mask_load_fsm (
	input logic clk,
	input logic reset,
	input logic start,
	input logic ack,
	input logic final_read,
	output logic cyc,
	output logic stb,
	output logic take_word,
	output logic mask_valid,
	output logic load_begin
);

	mask_loader_pkg::load_state_t state;
	mask_loader_pkg::load_state_t state_next;

	// ****************************************
	// state register
	// ****************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mask_loader_pkg::st_idle;
		end else begin
			state <= state_next;
		end
	end

	// ****************************************
	// next state
	// ****************************************

	always_comb begin
		state_next = state;
		case (state)
			mask_loader_pkg::st_idle: begin
				if (start) begin
					state_next = mask_loader_pkg::st_fetch;
				end
			end
			// read in flight, wait as long as the slave needs
			mask_loader_pkg::st_fetch: begin
				if (ack) begin
					if (final_read) begin
						state_next = mask_loader_pkg::st_loaded;
					end else begin
						state_next = mask_loader_pkg::st_advance;
					end
				end
			end
			// one idle cycle while the address steps
			mask_loader_pkg::st_advance: begin
				state_next = mask_loader_pkg::st_fetch;
			end
			// reload allowed here, not during a fetch
			mask_loader_pkg::st_loaded: begin
				if (start) begin
					state_next = mask_loader_pkg::st_fetch;
				end
			end
			default: begin
				state_next = mask_loader_pkg::st_idle;
			end
		endcase
	end

	// ****************************************
	// outputs
	// ****************************************

	// cyc and stb move together, one read outstanding at most
	assign cyc = (state == mask_loader_pkg::st_fetch);
	assign stb = (state == mask_loader_pkg::st_fetch);

	// word is accepted only while our strobe is up
	assign take_word = ack && (state == mask_loader_pkg::st_fetch);

	assign mask_valid = (state == mask_loader_pkg::st_loaded);

	// start is ignored while a load is running
	assign load_begin = start && ((state == mask_loader_pkg::st_idle) ||
		(state == mask_loader_pkg::st_loaded));

endmodule

// ==== verilog/fetch_counter.sv ====
// read bookkeeping of the mask load: bus address, completed-read count and last-read flag
`timescale 1ns/1ps
`include "mask_loader_config.svh"

module fetch_counter (
	input logic clk,
	input logic reset,
	input logic load_begin,
	input logic take_word,
	input mask_loader_pkg::mask_cfg_t cfg,
	output mask_loader_pkg::mem_addr_t adr,
	output mask_loader_pkg::fetch_count_t count,
	output logic final_read
);

	// number of words the current mask needs
	mask_loader_pkg::fetch_count_t target;
	mask_loader_pkg::fetch_count_t target_sel;

	// ****************************************
	// size to read count
	// ****************************************

	always_comb begin
		case (cfg.size)
			mask_loader_pkg::mask_size_t'(3): target_sel = mask_loader_pkg::fetch_count_t'(`READS_3X3);
			mask_loader_pkg::mask_size_t'(5): target_sel = mask_loader_pkg::fetch_count_t'(`READS_5X5);
			// unsupported sizes fetch a single word
			default: target_sel = mask_loader_pkg::fetch_count_t'(1);
		endcase
	end

	// ****************************************
	// address and count registers
	// ****************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			adr <= '0;
			count <= '0;
			target <= '0;
		end else if (load_begin) begin
			// latch the request, restart counting
			adr <= cfg.base;
			count <= '0;
			target <= target_sel;
		end else if (take_word) begin
			// next word sits one word further on
			adr <= adr + mask_loader_pkg::mem_addr_t'(`WORD_BYTES);
			count <= count + 1'b1;
		end
	end

	// the read now on the bus is the last one of the mask
	assign final_read = (count == mask_loader_pkg::fetch_count_t'(target - 1'b1));

endmodule

// ==== verilog/coeff_bank.sv ====
// coefficient storage: each accepted word is split into three entries of the current group
`timescale 1ns/1ps
`include "mask_loader_config.svh"

module coeff_bank (
	input logic clk,
	input logic reset,
	input logic take_word,
	input mask_loader_pkg::fetch_count_t count,
	input mask_loader_pkg::mem_word_t dat,
	output mask_loader_pkg::coeff_bank_t coeffs
);

	mask_loader_pkg::coeff_bank_t bank;

	// ****************************************
	// group capture
	// ****************************************

	// word k fills entries 3k, 3k+1, 3k+2 from the high field down
	// the two top bits of the word carry nothing
	always_ff @(posedge clk) begin
		if (reset) begin
			bank <= '0;
		end else if (take_word) begin
			for (int i = 0; i < `MASK_COEFFS; i++) begin
				// group of entry i is decoded straight from the read count
				if (count == mask_loader_pkg::fetch_count_t'(i / `COEFFS_PER_WORD)) begin
					bank[i] <= dat[`COEFF_BITS *
						(`COEFFS_PER_WORD - 1 - (i % `COEFFS_PER_WORD)) +: `COEFF_BITS];
				end
			end
		end
	end

	// entries of other groups simply hold
	assign coeffs = bank;

endmodule

// ==== verilog/mask_loader.sv ====
// mask coefficient loader top: wishbone read master feeding a 27-entry coefficient bank
`timescale 1ns/1ps

module mask_loader (
	input logic clk,
	input logic reset,
	input logic start,
	input mask_loader_pkg::mask_cfg_t cfg,
	input mask_loader_pkg::wb_rsp_t wb_rsp,
	output mask_loader_pkg::wb_req_t wb_req,
	output logic mask_valid,
	output mask_loader_pkg::coeff_bank_t coeffs
);

	// ****************************************
	// internal nets
	// ****************************************

	logic cyc;
	logic stb;
	mask_loader_pkg::mem_addr_t adr;
	// ack seen during a fetch
	logic take_word;
	logic final_read;
	// start accepted by the sequencer
	logic load_begin;
	// completed reads, selects the bank group
	mask_loader_pkg::fetch_count_t count;

	// ****************************************
	// sequencer
	// ****************************************

	mask_load_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.start(start),
		.ack(wb_rsp.ack),
		.final_read(final_read),
		.cyc(cyc),
		.stb(stb),
		.take_word(take_word),
		.mask_valid(mask_valid),
		.load_begin(load_begin)
	);

	// address and read count
	fetch_counter u_counter (
		.clk(clk),
		.reset(reset),
		.load_begin(load_begin),
		.take_word(take_word),
		.cfg(cfg),
		.adr(adr),
		.count(count),
		.final_read(final_read)
	);

	// unpacking into the bank
	coeff_bank u_bank (
		.clk(clk),
		.reset(reset),
		.take_word(take_word),
		.count(count),
		.dat(wb_rsp.dat),
		.coeffs(coeffs)
	);

	// bus request gathered from fsm and counter
	assign wb_req = '{cyc: cyc, stb: stb, adr: adr};

endmodule

// ==== tb/mask_loader_assertions.sv ====
// wishbone protocol and mask-valid checks, bound into the loader top level
`timescale 1ns/1ps

module mask_loader_assertions (
	input logic clk,
	input logic reset,
	input mask_loader_pkg::wb_req_t wb_req,
	input logic ack,
	input logic mask_valid
);

	// failure tallies per check
	int strobe_fails = 0;
	int hold_fails = 0;
	int valid_fails = 0;

	// cyc and stb both drop in the cycle after an ack
	cycle_ends_on_ack: assert property (@(posedge clk) disable iff (reset)
		(wb_req.stb && ack) |=> (!wb_req.cyc && !wb_req.stb))
	else begin
		$error("cyc or stb still high after ack");
		strobe_fails++;
	end

	// request held with the same address until the slave answers
	request_held: assert property (@(posedge clk) disable iff (reset)
		(wb_req.stb && !ack) |=> (wb_req.stb && $stable(wb_req.adr)))
	else begin
		$error("stb or adr changed before ack");
		hold_fails++;
	end

	// mask complete only right after an acknowledged read
	valid_after_ack: assert property (@(posedge clk) disable iff (reset)
		$rose(mask_valid) |-> $past(wb_req.stb && ack))
	else begin
		$error("mask_valid rose without an acknowledged read");
		valid_fails++;
	end

endmodule

// strobes from the fsm, address from the counter, both visible at the top
bind mask_loader mask_loader_assertions u_checks (
	.clk(clk),
	.reset(reset),
	.wb_req(wb_req),
	.ack(wb_rsp.ack),
	.mask_valid(mask_valid)
);

// ==== tb/mask_loader_tb.sv ====
// testbench for the mask loader: wishbone memory model, directed loads and coefficient checks
`timescale 1ns/1ps
`include "mask_loader_config.svh"

module mask_loader_tb;

	// ****************************************
	// run limits
	// ****************************************

	// all tests together issue 34 reads
	localparam int total_reads = 34;
	// worst read: 3 wait cycles, ack, advance cycle and start overhead
	localparam int cycles_per_read = 6;
	// ten-fold margin over the busiest case
	localparam int timeout_cycles = 10 * total_reads * cycles_per_read;
	localparam int mem_words = 1 << (`ADDR_BITS - 2);

	logic clk;
	logic reset;
	logic start;
	mask_loader_pkg::mask_cfg_t cfg;
	mask_loader_pkg::wb_rsp_t wb_rsp = '0;
	mask_loader_pkg::wb_req_t wb_req;
	logic mask_valid;
	mask_loader_pkg::coeff_bank_t coeffs;

	// memory model state
	mask_loader_pkg::mem_word_t mem [mem_words];
	// addresses of acknowledged reads, oldest first
	mask_loader_pkg::mem_addr_t seen_adr [$];
	integer seed = 9746;
	int wait_max = 0;
	int waits_left = 0;

	// expected bank contents and tallies
	mask_loader_pkg::coeff_t exp_bank [`MASK_COEFFS];
	int check_count = 0;
	int error_count = 0;
	int cycle_count = 0;

	mask_loader dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.cfg(cfg),
		.wb_rsp(wb_rsp),
		.wb_req(wb_req),
		.mask_valid(mask_valid),
		.coeffs(coeffs)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d cycles", cycle_count);
		$display("Errors found");
		$finish;
	end

	// ****************************************
	// wishbone memory model
	// ****************************************

	// wait states before the next ack, 0 to wait_max
	function automatic int pick_wait();
		return int'({$random(seed)} % (wait_max + 1));
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			wb_rsp <= '0;
			waits_left <= 0;
		end else if (wb_rsp.ack) begin
			// master drops stb now, ack lasts one cycle
			wb_rsp.ack <= 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (waits_left == 0) begin
				wb_rsp <= '{ack: 1'b1, dat: mem[wb_req.adr[`ADDR_BITS-1:2]]};
				seen_adr.push_back(wb_req.adr);
				waits_left <= pick_wait();
			end else begin
				waits_left <= waits_left - 1;
			end
		end
	end

	// ****************************************
	// compare tasks
	// ****************************************

	task automatic check_coeff(input int idx, input mask_loader_pkg::coeff_t got,
		input mask_loader_pkg::coeff_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: coefficient %0d is %h, expected %h", $time, idx, got, exp);
		end
	endtask

	task automatic check_addr(input int idx, input mask_loader_pkg::mem_addr_t got,
		input mask_loader_pkg::mem_addr_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: read %0d went to %h, expected %h", $time, idx, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// field j of a word, high field first
	function automatic mask_loader_pkg::coeff_t field_of(input mask_loader_pkg::mem_word_t w,
		input int j);
		case (j)
			0: return w[29:20];
			1: return w[19:10];
			default: return w[9:0];
		endcase
	endfunction

	// ****************************************
	// load sequencing
	// ****************************************

	task automatic pulse_start(input mask_loader_pkg::mask_size_t size,
		input mask_loader_pkg::mem_addr_t base);
		@(posedge clk);
		start <= 1'b1;
		cfg <= '{size: size, base: base};
		@(posedge clk);
		start <= 1'b0;
	endtask

	// mask_valid must not rise before the last ack
	task automatic wait_loaded(input int reads);
		while (!mask_valid) begin
			@(negedge clk);
		end
		check_flag("all reads done at mask_valid", seen_adr.size() == reads, 1'b1);
	endtask

	// addresses, then the whole bank against the memory contents
	task automatic check_reads(input mask_loader_pkg::mem_addr_t base, input int reads);
		mask_loader_pkg::mem_addr_t exp_adr;
		for (int k = 0; k < reads; k++) begin
			exp_adr = base + mask_loader_pkg::mem_addr_t'(k * `WORD_BYTES);
			if (k < seen_adr.size()) begin
				check_addr(k, seen_adr[k], exp_adr);
			end
			for (int j = 0; j < `COEFFS_PER_WORD; j++) begin
				exp_bank[`COEFFS_PER_WORD * k + j] = field_of(mem[exp_adr[`ADDR_BITS-1:2]], j);
			end
		end
		for (int i = 0; i < `MASK_COEFFS; i++) begin
			check_coeff(i, coeffs[i], exp_bank[i]);
		end
	endtask

	task automatic run_load(input mask_loader_pkg::mask_size_t size,
		input mask_loader_pkg::mem_addr_t base, input int reads);
		seen_adr.delete();
		pulse_start(size, base);
		// a reload drops mask_valid right after start
		@(negedge clk);
		check_flag("mask_valid after start", mask_valid, 1'b0);
		wait_loaded(reads);
		check_reads(base, reads);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (error_count == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d failed checks", name, error_count - errs_before);
		end
	endtask

	// ****************************************
	// tests
	// ****************************************

	task automatic test_3x3();
		int errs_before;
		errs_before = error_count;
		wait_max = 0;
		run_load(3'd3, 10'h040, `READS_3X3);
		report_test("3x3 load from 0x040", errs_before);
	endtask

	task automatic test_5x5();
		int errs_before;
		errs_before = error_count;
		wait_max = 0;
		run_load(3'd5, 10'h100, `READS_5X5);
		report_test("5x5 load from 0x100", errs_before);
	endtask

	// size 7 falls back to one word, entries 3 and up keep the 5x5 data
	task automatic test_odd_size();
		int errs_before;
		errs_before = error_count;
		wait_max = 1;
		run_load(3'd7, 10'h200, 1);
		report_test("unsupported size 7", errs_before);
	endtask

	task automatic test_wait_states();
		int errs_before;
		errs_before = error_count;
		wait_max = 3;
		run_load(3'd5, 10'h300, `READS_5X5);
		report_test("5x5 load with wait states", errs_before);
	endtask

	task automatic test_start_ignored();
		int errs_before;
		errs_before = error_count;
		wait_max = 2;
		seen_adr.delete();
		pulse_start(3'd5, 10'h080);
		while (seen_adr.size() < 2) begin
			@(negedge clk);
		end
		// mid-load start with another request must change nothing
		pulse_start(3'd3, 10'h3c0);
		wait_loaded(`READS_5X5);
		check_reads(10'h080, `READS_5X5);
		// start while loaded reloads from the new base
		run_load(3'd3, 10'h3c0, `READS_3X3);
		report_test("start during load and reload", errs_before);
	endtask

	// ****************************************
	// main sequence
	// ****************************************

	initial begin
		int assert_fails;
		reset = 1'b1;
		start = 1'b0;
		cfg = '0;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = $random(seed);
		end
		for (int i = 0; i < `MASK_COEFFS; i++) begin
			exp_bank[i] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_3x3();
		test_5x5();
		test_odd_size();
		test_wait_states();
		test_start_ignored();
		assert_fails = dut.u_checks.strobe_fails + dut.u_checks.hold_fails +
			dut.u_checks.valid_fails;
		$display("%0d checks, %0d errors, %0d assertion failures",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== mask_loader.f ====
+incdir+verilog
verilog/mask_loader_pkg.sv
verilog/mask_load_fsm.sv
verilog/fetch_counter.sv
verilog/coeff_bank.sv
verilog/mask_loader.sv
tb/mask_loader_assertions.sv
tb/mask_loader_tb.sv

// ==== Makefile ====
# Verilator build and run of the mask loader testbench

VERILATOR ?= verilator
TOP ?= mask_loader_tb
FILELIST ?= mask_loader.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)
